//--- srio_resp_defines.svh
`ifndef SRIO_RESP_DEFINES_SVH
`define SRIO_RESP_DEFINES_SVH

// axi-stream widths on both request and response sides
`define SRIO_DATA_W 64
`define SRIO_KEEP_W 8

// device id width, 16-bit (large) ids
`define SRIO_ID_W 16

// pending response commands
`define RESP_QUEUE_DEPTH 16

`endif

//--- srio_resp_pkg.sv
`include "srio_resp_defines.svh"

package srio_resp_pkg;

    // header field types
    typedef logic [`SRIO_ID_W-1:0] srio_id_t;
    typedef logic [7:0]            tid_t;
    typedef logic [1:0]            prio_t;
    // byte count minus one
    typedef logic [7:0]            size_t;

    // logical-layer format types
    typedef enum logic [3:0]
    {
        NREAD  = 4'h2,
        NWRITE = 4'h5,
        SWRITE = 4'h6,
        DOORB  = 4'hA,
        MESSG  = 4'hB,
        RESP   = 4'hD
    } ftype_e;

    // ttype within the NWRITE class
    typedef enum logic [3:0]
    {
        TTYPE_NWRITE   = 4'h4,
        TTYPE_NWRITE_R = 4'h5
    } req_ttype_e;

    // ttype of a response packet
    typedef enum logic [3:0]
    {
        TNDATA = 4'h0,
        MSGRSP = 4'h1,
        TWDATA = 4'h8
    } resp_ttype_e;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_HEADER,
        ST_DATA
    } builder_state_e;

endpackage

//--- resp_cmd_if.sv
`timescale 1ns/100ps

// one pending response, valid/ready handshake
interface resp_cmd_if;
    import srio_resp_pkg::*;

    logic     valid;
    logic     ready;
    tid_t     tid;
    ftype_e   ftype;
    prio_t    prio;
    size_t    size;
    srio_id_t dest_id;

    modport source
    (
        output valid, tid, ftype, prio, size, dest_id,
        input  ready
    );

    modport sink
    (
        input  valid, tid, ftype, prio, size, dest_id,
        output ready
    );

endinterface

//--- req_decoder.sv
`timescale 1ns/100ps
`include "srio_resp_defines.svh"

module req_decoder
(
    input  logic                    log_clk,
    input  logic                    log_rst_q,
    input  logic                    treq_tvalid,
    output logic                    treq_tready,
    input  logic                    treq_tlast,
    input  logic [`SRIO_DATA_W-1:0] treq_tdata,
    input  logic [31:0]             treq_tuser,
    resp_cmd_if.source              cmd
);
    import srio_resp_pkg::*;

    logic       first_beat_q;
    logic       treq_fire;
    ftype_e     req_ftype;
    req_ttype_e req_ttype;
    logic       needs_resp;

    // no new beat while the command register is still occupied
    assign treq_tready = cmd.ready;
    assign treq_fire   = treq_tvalid && treq_tready;

    assign req_ftype = ftype_e'(treq_tdata[55:52]);
    assign req_ttype = req_ttype_e'(treq_tdata[51:48]);

    // swrite and plain nwrite are posted
    assign needs_resp = (req_ftype == NREAD) ||
                        (req_ftype == DOORB) ||
                        (req_ftype == MESSG) ||
                        ((req_ftype == NWRITE) && (req_ttype == TTYPE_NWRITE_R));

    always_ff @(posedge log_clk)
    begin
        if (log_rst_q)
        begin
            first_beat_q <= 1'b1;
        end
        else if (treq_fire)
        begin
            first_beat_q <= treq_tlast;
        end
    end

    always_ff @(posedge log_clk)
    begin
        if (log_rst_q)
        begin
            cmd.valid <= 1'b0;
        end
        else if (treq_fire && first_beat_q && needs_resp)
        begin
            cmd.valid <= 1'b1;
        end
        else if (cmd.ready)
        begin
            cmd.valid <= 1'b0;
        end
    end

    // header fields, priority bumped by one and wrapping
    always_ff @(posedge log_clk)
    begin
        if (treq_fire && first_beat_q)
        begin
            cmd.tid     <= tid_t'(treq_tdata[63:56]);
            cmd.ftype   <= req_ftype;
            cmd.prio    <= prio_t'(treq_tdata[46:45] + 2'd1);
            cmd.size    <= size_t'(treq_tdata[43:36]);
            cmd.dest_id <= srio_id_t'(treq_tuser[31:16]);
        end
    end

    // a pending command must survive until the queue takes it
    assert property (@(posedge log_clk) disable iff (log_rst_q)
        cmd.valid && !cmd.ready |=> cmd.valid && $stable(cmd.tid) && $stable(cmd.dest_id));

endmodule

//--- resp_cmd_fifo.sv
`timescale 1ns/100ps
`include "srio_resp_defines.svh"

module resp_cmd_fifo
#(
    parameter int DEPTH = `RESP_QUEUE_DEPTH
)
(
    input  logic      log_clk,
    input  logic      log_rst_q,
    resp_cmd_if.sink   wr,
    resp_cmd_if.source rd
);
    import srio_resp_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    typedef struct packed
    {
        tid_t     tid;
        ftype_e   ftype;
        prio_t    prio;
        size_t    size;
        srio_id_t dest_id;
    } entry_t;

    entry_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic [CNT_W-1:0]   count_next;
    logic               wr_fire;
    logic               rd_fire;
    entry_t             head;

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    always_comb
    begin
        count_next = count_q;
        if (wr_fire && !rd_fire)
        begin
            count_next = count_q + 1'b1;
        end
        else if (rd_fire && !wr_fire)
        begin
            count_next = count_q - 1'b1;
        end
    end

    always_ff @(posedge log_clk)
    begin
        if (log_rst_q)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            wr.ready <= 1'b0;
            rd.valid <= 1'b0;
        end
        else
        begin
            if (wr_fire)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_fire)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q  <= count_next;
            // flags registered from the next occupancy
            wr.ready <= (count_next != CNT_W'(DEPTH));
            rd.valid <= (count_next != '0);
        end
    end

    always_ff @(posedge log_clk)
    begin
        if (wr_fire)
        begin
            mem[wr_ptr_q] <= '{wr.tid, wr.ftype, wr.prio, wr.size, wr.dest_id};
        end
    end

    // head slot is only rewritten after it has been popped
    assign head       = mem[rd_ptr_q];
    assign rd.tid     = head.tid;
    assign rd.ftype   = head.ftype;
    assign rd.prio    = head.prio;
    assign rd.size    = head.size;
    assign rd.dest_id = head.dest_id;

    assert property (@(posedge log_clk) disable iff (log_rst_q)
        wr_fire |-> count_q < CNT_W'(DEPTH) || rd_fire);

    assert property (@(posedge log_clk) disable iff (log_rst_q)
        rd_fire |-> count_q != '0);

endmodule

//--- resp_builder.sv
`timescale 1ns/100ps
`include "srio_resp_defines.svh"

module resp_builder
(
    input  logic                     log_clk,
    input  logic                     log_rst_q,
    resp_cmd_if.sink                 cmd,
    input  srio_resp_pkg::srio_id_t  src_id,
    output logic                     tresp_tvalid,
    input  logic                     tresp_tready,
    output logic                     tresp_tlast,
    output logic [`SRIO_DATA_W-1:0]  tresp_tdata,
    output logic [31:0]              tresp_tuser
);
    import srio_resp_pkg::*;

    builder_state_e state_q;
    resp_ttype_e    rsp_ttype;
    logic           nread_q;
    logic [4:0]     beats_left_q;
    logic [7:0]     pattern_q;
    srio_id_t       dest_q;
    logic           tresp_fire;
    logic           cmd_fire;

    assign cmd.ready  = (state_q == ST_IDLE);
    assign cmd_fire   = cmd.valid && cmd.ready;
    assign tresp_fire = tresp_tvalid && tresp_tready;

    always_comb
    begin
        case (cmd.ftype)
            NREAD:   rsp_ttype = TWDATA;
            MESSG:   rsp_ttype = MSGRSP;
            default: rsp_ttype = TNDATA;
        endcase
    end

    always_ff @(posedge log_clk)
    begin
        if (log_rst_q)
        begin
            state_q      <= ST_IDLE;
            tresp_tvalid <= 1'b0;
            tresp_tlast  <= 1'b0;
            nread_q      <= 1'b0;
            beats_left_q <= '0;
            pattern_q    <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (cmd_fire)
                    begin
                        state_q      <= ST_HEADER;
                        tresp_tvalid <= 1'b1;
                        tresp_tlast  <= (cmd.ftype != NREAD);
                        nread_q      <= (cmd.ftype == NREAD);
                        // size[7:3]+1 data beats follow for nread
                        beats_left_q <= cmd.size[7:3];
                    end
                end
                ST_HEADER:
                begin
                    if (tresp_fire)
                    begin
                        if (nread_q)
                        begin
                            state_q     <= ST_DATA;
                            tresp_tlast <= (beats_left_q == '0);
                        end
                        else
                        begin
                            state_q      <= ST_IDLE;
                            tresp_tvalid <= 1'b0;
                            tresp_tlast  <= 1'b0;
                        end
                    end
                end
                ST_DATA:
                begin
                    if (tresp_fire)
                    begin
                        // pattern runs on across responses
                        pattern_q <= pattern_q + 8'd1;
                        if (tresp_tlast)
                        begin
                            state_q      <= ST_IDLE;
                            tresp_tvalid <= 1'b0;
                            tresp_tlast  <= 1'b0;
                        end
                        else
                        begin
                            beats_left_q <= beats_left_q - 5'd1;
                            tresp_tlast  <= (beats_left_q == 5'd1);
                        end
                    end
                end
                default:
                begin
                    state_q      <= ST_IDLE;
                    tresp_tvalid <= 1'b0;
                    tresp_tlast  <= 1'b0;
                end
            endcase
        end
    end

    // beat payload, held until accepted
    always_ff @(posedge log_clk)
    begin
        if (cmd_fire)
        begin
            tresp_tdata <= {cmd.tid, RESP, rsp_ttype, 1'b0, cmd.prio, 45'h0};
            dest_q      <= cmd.dest_id;
        end
        else if (tresp_fire && state_q == ST_HEADER)
        begin
            tresp_tdata <= {8{pattern_q}};
        end
        else if (tresp_fire && state_q == ST_DATA)
        begin
            tresp_tdata <= {8{pattern_q + 8'd1}};
        end
    end

    assign tresp_tuser = {src_id, dest_q};

    assert property (@(posedge log_clk) disable iff (log_rst_q)
        tresp_tvalid && !tresp_tready |=> tresp_tvalid && $stable(tresp_tdata));

endmodule

//--- srio_resp_top.sv
`timescale 1ns/100ps
`include "srio_resp_defines.svh"

module srio_resp_top
(
    input  logic                     log_clk,
    input  logic                     log_rst_q,

    input  srio_resp_pkg::srio_id_t  deviceid,
    input  srio_resp_pkg::srio_id_t  source_id,
    input  logic                     id_override,

    input  logic                     treq_tvalid,
    output logic                     treq_tready,
    input  logic                     treq_tlast,
    input  logic [`SRIO_DATA_W-1:0]  treq_tdata,
    input  logic [`SRIO_KEEP_W-1:0]  treq_tkeep,
    input  logic [31:0]              treq_tuser,

    output logic                     tresp_tvalid,
    input  logic                     tresp_tready,
    output logic                     tresp_tlast,
    output logic [`SRIO_DATA_W-1:0]  tresp_tdata,
    output logic [`SRIO_KEEP_W-1:0]  tresp_tkeep,
    output logic [31:0]              tresp_tuser
);
    import srio_resp_pkg::*;

    srio_id_t src_id;

    resp_cmd_if cmd_in ();
    resp_cmd_if cmd_out ();

    // override id replaces the device id in responses
    assign src_id = id_override ? source_id : deviceid;

    // responses are always whole words
    assign tresp_tkeep = '1;

    req_decoder req_decoder_inst
    (
        .log_clk     (log_clk),
        .log_rst_q   (log_rst_q),
        .treq_tvalid (treq_tvalid),
        .treq_tready (treq_tready),
        .treq_tlast  (treq_tlast),
        .treq_tdata  (treq_tdata),
        .treq_tuser  (treq_tuser),
        .cmd         (cmd_in.source)
    );

    resp_cmd_fifo #(
        .DEPTH (`RESP_QUEUE_DEPTH)
    ) resp_cmd_fifo_inst (
        .log_clk   (log_clk),
        .log_rst_q (log_rst_q),
        .wr        (cmd_in.sink),
        .rd        (cmd_out.source)
    );

    resp_builder resp_builder_inst
    (
        .log_clk      (log_clk),
        .log_rst_q    (log_rst_q),
        .cmd          (cmd_out.sink),
        .src_id       (src_id),
        .tresp_tvalid (tresp_tvalid),
        .tresp_tready (tresp_tready),
        .tresp_tlast  (tresp_tlast),
        .tresp_tdata  (tresp_tdata),
        .tresp_tuser  (tresp_tuser)
    );

endmodule

//--- tb_srio_resp.sv
`timescale 1ns/100ps
`include "srio_resp_defines.svh"

module tb_srio_resp;
    import srio_resp_pkg::*;

    localparam int       NUM_ROWS   = 36;
    localparam int       WAIT_LIMIT = 2000;
    localparam srio_id_t DEV_ID     = 16'h00A1;
    localparam srio_id_t OVR_ID     = 16'h0B52;

    typedef struct packed
    {
        ftype_e      ftype;
        logic [3:0]  ttype;
        tid_t        tid;
        prio_t       prio;
        size_t       size;
        srio_id_t    req_id;
        logic [3:0]  beats;
        logic        ovr;
        logic        has_resp;
        resp_ttype_e resp_ttype;
        logic [5:0]  data_beats;
    } row_t;

    typedef struct packed
    {
        tid_t        tid;
        resp_ttype_e ttype;
        prio_t       prio;
        srio_id_t    dest;
        srio_id_t    src;
        logic [5:0]  data_beats;
    } expect_t;

    logic                    log_clk;
    logic                    log_rst_q;
    srio_id_t                deviceid;
    srio_id_t                source_id;
    logic                    id_override;
    logic                    treq_tvalid;
    logic                    treq_tready;
    logic                    treq_tlast;
    logic [`SRIO_DATA_W-1:0] treq_tdata;
    logic [`SRIO_KEEP_W-1:0] treq_tkeep;
    logic [31:0]             treq_tuser;
    logic                    tresp_tvalid;
    logic                    tresp_tready;
    logic                    tresp_tlast;
    logic [`SRIO_DATA_W-1:0] tresp_tdata;
    logic [`SRIO_KEEP_W-1:0] tresp_tkeep;
    logic [31:0]             tresp_tuser;

    row_t                    rows [NUM_ROWS];
    expect_t                 exp_q [$];
    expect_t                 cur;
    integer                  seed;
    int                      value_errors;
    int                      protocol_errors;
    int                      sent_count;
    int                      recv_count;
    int                      data_left;
    int                      i;
    logic                    timed_out;
    logic                    in_packet;
    logic [7:0]              model_pat;
    logic                    stall_q;
    logic [`SRIO_DATA_W-1:0] stall_data_q;

    srio_resp_top srio_resp_top_inst
    (
        .log_clk      (log_clk),
        .log_rst_q    (log_rst_q),
        .deviceid     (deviceid),
        .source_id    (source_id),
        .id_override  (id_override),
        .treq_tvalid  (treq_tvalid),
        .treq_tready  (treq_tready),
        .treq_tlast   (treq_tlast),
        .treq_tdata   (treq_tdata),
        .treq_tkeep   (treq_tkeep),
        .treq_tuser   (treq_tuser),
        .tresp_tvalid (tresp_tvalid),
        .tresp_tready (tresp_tready),
        .tresp_tlast  (tresp_tlast),
        .tresp_tdata  (tresp_tdata),
        .tresp_tkeep  (tresp_tkeep),
        .tresp_tuser  (tresp_tuser)
    );

    always #20 log_clk = ~log_clk;

    // random back-pressure, ready about three beats in four
    always
    begin
        @(posedge log_clk);
        #2;
        tresp_tready = (($random(seed) & 3) != 0);
    end

    task automatic set_row(input int idx, input ftype_e f, input logic [3:0] tt,
                           input tid_t tid, input prio_t p, input size_t s,
                           input srio_id_t id, input int beats, input logic ovr,
                           input logic has, input resp_ttype_e rtt, input int ndata);
        rows[idx] = '{f, tt, tid, p, s, id, beats[3:0], ovr, has, rtt, ndata[5:0]};
    endtask

    task automatic build_table();
        int k;
        set_row(0,  NREAD,  4'h4,           8'h01, 2'd0, 8'h07, 16'h1001, 1, 0, 1, TWDATA, 1);
        set_row(1,  DOORB,  4'h0,           8'h02, 2'd1, 8'h01, 16'h1002, 1, 0, 1, TNDATA, 0);
        set_row(2,  MESSG,  4'h0,           8'h03, 2'd2, 8'h3F, 16'h1003, 3, 0, 1, MSGRSP, 0);
        set_row(3,  NWRITE, TTYPE_NWRITE_R, 8'h04, 2'd3, 8'h0F, 16'h1004, 3, 0, 1, TNDATA, 0);
        set_row(4,  SWRITE, 4'h0,           8'h05, 2'd1, 8'h1F, 16'h1005, 5, 0, 0, TNDATA, 0);
        set_row(5,  NWRITE, TTYPE_NWRITE,   8'h06, 2'd2, 8'h07, 16'h1006, 2, 0, 0, TNDATA, 0);
        set_row(6,  NREAD,  4'h4,           8'h07, 2'd2, 8'h3F, 16'h1007, 1, 0, 1, TWDATA, 8);
        set_row(7,  NREAD,  4'h4,           8'h08, 2'd1, 8'h1F, 16'h1008, 1, 1, 1, TWDATA, 4);
        set_row(8,  DOORB,  4'h0,           8'h09, 2'd3, 8'h00, 16'h2009, 1, 1, 1, TNDATA, 0);
        set_row(9,  MESSG,  4'h0,           8'h0A, 2'd0, 8'h07, 16'h200A, 2, 1, 1, MSGRSP, 0);
        set_row(10, NWRITE, TTYPE_NWRITE_R, 8'h0B, 2'd1, 8'h07, 16'h200B, 2, 1, 1, TNDATA, 0);
        set_row(11, NREAD,  4'h4,           8'h0C, 2'd0, 8'hFF, 16'h200C, 1, 0, 1, TWDATA, 32);
        // burst behind the long nread, enough to fill the queue
        for (k = 0; k < 24; k++)
        begin
            case (k % 4)
                0: set_row(12 + k, DOORB, 4'h0, tid_t'(8'h40 + k), prio_t'(k), 8'h00,
                           srio_id_t'(16'h3000 + k), 1, 0, 1, TNDATA, 0);
                1: set_row(12 + k, MESSG, 4'h0, tid_t'(8'h40 + k), prio_t'(k), 8'h07,
                           srio_id_t'(16'h3000 + k), 1, 0, 1, MSGRSP, 0);
                2: set_row(12 + k, NREAD, 4'h4, tid_t'(8'h40 + k), prio_t'(k), 8'h08,
                           srio_id_t'(16'h3000 + k), 1, 0, 1, TWDATA, 2);
                default: set_row(12 + k, SWRITE, 4'h0, tid_t'(8'h40 + k), prio_t'(k), 8'h0F,
                                 srio_id_t'(16'h3000 + k), 2, 0, 0, TNDATA, 0);
            endcase
        end
    endtask

    task automatic check_header(input tid_t got_tid, input tid_t exp_tid,
                                input resp_ttype_e got_tt, input resp_ttype_e exp_tt,
                                input prio_t got_prio, input prio_t exp_prio,
                                input logic [3:0] got_ftype, input ftype_e exp_ftype);
        if (got_tid !== exp_tid)
        begin
            value_errors++;
            $display("FAILED tresp_tdata tid: got %h, expected %h", got_tid, exp_tid);
        end
        if (got_tt !== exp_tt)
        begin
            value_errors++;
            $display("FAILED tresp_tdata ttype: got %h, expected %h", got_tt, exp_tt);
        end
        if (got_prio !== exp_prio)
        begin
            value_errors++;
            $display("FAILED tresp_tdata prio: got %h, expected %h", got_prio, exp_prio);
        end
        if (got_ftype !== exp_ftype)
        begin
            value_errors++;
            $display("FAILED tresp_tdata ftype: got %h, expected %h", got_ftype, exp_ftype);
        end
    endtask

    task automatic check_data(input string name, input logic [`SRIO_DATA_W-1:0] got,
                              input logic [`SRIO_DATA_W-1:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_tuser(input srio_id_t got_src, input srio_id_t exp_src,
                               input srio_id_t got_dest, input srio_id_t exp_dest);
        if (got_src !== exp_src)
        begin
            value_errors++;
            $display("FAILED tresp_tuser source: got %h, expected %h", got_src, exp_src);
        end
        if (got_dest !== exp_dest)
        begin
            value_errors++;
            $display("FAILED tresp_tuser dest: got %h, expected %h", got_dest, exp_dest);
        end
    endtask

    task automatic check_ctrl(input logic got_last, input logic exp_last,
                              input logic [`SRIO_KEEP_W-1:0] got_keep);
        if (got_last !== exp_last)
        begin
            value_errors++;
            $display("FAILED tresp_tlast: got %h, expected %h", got_last, exp_last);
        end
        if (got_keep !== {`SRIO_KEEP_W{1'b1}})
        begin
            value_errors++;
            $display("FAILED tresp_tkeep: got %h, expected %h", got_keep, {`SRIO_KEEP_W{1'b1}});
        end
    endtask

    // returns one cycle after the beat is accepted, inputs may change then
    task automatic wait_ready();
        int cnt;
        cnt = 0;
        @(negedge log_clk);
        while (!treq_tready && cnt < WAIT_LIMIT)
        begin
            @(negedge log_clk);
            cnt++;
        end
        if (!treq_tready)
        begin
            timed_out = 1'b1;
            $display("timeout: treq_tready stayed low for %0d cycles", WAIT_LIMIT);
        end
        else
        begin
            @(posedge log_clk);
            #2;
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        @(posedge log_clk);
        while ((exp_q.size() != 0 || in_packet) && cnt < WAIT_LIMIT)
        begin
            @(posedge log_clk);
            cnt++;
        end
        if (exp_q.size() != 0 || in_packet)
        begin
            timed_out = 1'b1;
            $display("timeout: %0d responses still outstanding", exp_q.size());
        end
    endtask

    task automatic send_row(input row_t r);
        int      b;
        expect_t e;
        for (b = 0; b < r.beats && !timed_out; b++)
        begin
            treq_tvalid = 1'b1;
            treq_tlast  = (b == r.beats - 1);
            treq_tkeep  = '1;
            treq_tuser  = {r.req_id, 16'h0000};
            if (b == 0)
            begin
                treq_tdata = {r.tid, r.ftype, r.ttype, 1'b0, r.prio, 1'b0, r.size, 36'h987654321};
            end
            else
            begin
                treq_tdata = {$random(seed), $random(seed)};
            end
            wait_ready();
            if (!timed_out && b == 0 && r.has_resp)
            begin
                e.tid        = r.tid;
                e.ttype      = r.resp_ttype;
                e.prio       = prio_t'(r.prio + 2'd1);
                e.dest       = r.req_id;
                e.src        = r.ovr ? OVR_ID : DEV_ID;
                e.data_beats = r.data_beats;
                exp_q.push_back(e);
                sent_count++;
            end
        end
        treq_tvalid = 1'b0;
        treq_tlast  = 1'b0;
    endtask

    task automatic take_beat();
        if (!in_packet)
        begin
            recv_count++;
            if (exp_q.size() == 0)
            begin
                protocol_errors++;
                $display("response header arrived with no request pending");
            end
            else
            begin
                cur = exp_q.pop_front();
                check_header(tid_t'(tresp_tdata[63:56]), cur.tid,
                             resp_ttype_e'(tresp_tdata[51:48]), cur.ttype,
                             prio_t'(tresp_tdata[46:45]), cur.prio,
                             tresp_tdata[55:52], RESP);
                check_data("tresp_tdata reserved bits",
                           {18'h0, tresp_tdata[47], tresp_tdata[44:0]}, '0);
                check_tuser(tresp_tuser[31:16], cur.src, tresp_tuser[15:0], cur.dest);
                check_ctrl(tresp_tlast, cur.data_beats == 0, tresp_tkeep);
                data_left = cur.data_beats;
                in_packet = (cur.data_beats != 0);
            end
        end
        else
        begin
            check_data("tresp_tdata", tresp_tdata, {8{model_pat}});
            model_pat = model_pat + 8'd1;
            data_left--;
            check_tuser(tresp_tuser[31:16], cur.src, tresp_tuser[15:0], cur.dest);
            check_ctrl(tresp_tlast, data_left == 0, tresp_tkeep);
            if (data_left == 0)
            begin
                in_packet = 1'b0;
            end
        end
    endtask

    // monitor, sampled mid-cycle ahead of the accepting edge
    always @(negedge log_clk)
    begin
        if (!log_rst_q)
        begin
            if (stall_q)
            begin
                if (!tresp_tvalid)
                begin
                    protocol_errors++;
                    $display("tresp_tvalid dropped before the beat was accepted");
                end
                else
                begin
                    check_data("tresp_tdata held", tresp_tdata, stall_data_q);
                end
            end
            stall_q      = tresp_tvalid && !tresp_tready;
            stall_data_q = tresp_tdata;
            if (tresp_tvalid && tresp_tready)
            begin
                take_beat();
            end
        end
    end

    initial
    begin
        seed            = 49262;
        log_clk         = 1'b0;
        log_rst_q       = 1'b1;
        deviceid        = DEV_ID;
        source_id       = OVR_ID;
        id_override     = 1'b0;
        treq_tvalid     = 1'b0;
        treq_tlast      = 1'b0;
        treq_tdata      = '0;
        treq_tkeep      = '0;
        treq_tuser      = '0;
        tresp_tready    = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        sent_count      = 0;
        recv_count      = 0;
        data_left       = 0;
        timed_out       = 1'b0;
        in_packet       = 1'b0;
        model_pat       = 8'h00;
        stall_q         = 1'b0;
        stall_data_q    = '0;
        build_table();

        repeat (4) @(posedge log_clk);
        #2;
        log_rst_q = 1'b0;

        for (i = 0; i < NUM_ROWS && !timed_out; i++)
        begin
            // source id is only switched with nothing in flight
            if (rows[i].ovr != id_override)
            begin
                wait_drain();
                #2;
                id_override = rows[i].ovr;
            end
            if (!timed_out)
            begin
                send_row(rows[i]);
            end
        end
        if (!timed_out)
        begin
            wait_drain();
        end
        if (!timed_out && recv_count != sent_count)
        begin
            protocol_errors++;
            $display("received %0d responses but %0d were expected", recv_count, sent_count);
        end

        $display("errors: %0d value, %0d protocol, %0d timeout; responses %0d of %0d",
                 value_errors, protocol_errors, timed_out, recv_count, sent_count);
        if (value_errors == 0 && protocol_errors == 0 && !timed_out)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
srio_resp_pkg.sv
resp_cmd_if.sv
req_decoder.sv
resp_cmd_fifo.sv
resp_builder.sv
srio_resp_top.sv
tb_srio_resp.sv

//--- Bender.yml
package:
  name: srio_resp

export_include_dirs:
  - .

sources:
  - files:
      - srio_resp_pkg.sv
      - resp_cmd_if.sv
      - req_decoder.sv
      - resp_cmd_fifo.sv
      - resp_builder.sv
      - srio_resp_top.sv
  - target: test
    files:
      - tb_srio_resp.sv
